// File: hdl/fm_spy_pkg.sv
// front-end monitor spy buffer package with the shared widths, depth and init pattern
package fm_spy_pkg;

	// number of spy channels in the bank
	localparam int n_channels_default = 4;        // default bank size, top level may override

	// monitored stream and spy memory word
	localparam int mon_dw = 32;                   // one width for every channel

	// spy memory geometry
	localparam int spy_aw    = 6;                 // spy address bits
	localparam int spy_depth = 1 << spy_aw;       // words per spy memory, 64

	// a single word of monitored or spy data
	typedef logic [mon_dw-1:0] mon_word_t;

	// address into one spy memory
	typedef logic [spy_aw-1:0] spy_addr_t;

	// fill word of the init sweep
	// a recognisable value, so untouched locations stand out in a dump
	localparam mon_word_t init_pattern = 32'h0fa5fa50;

endpackage

// File: hdl/spy_channel.sv
// spy channel with one-cycle passthrough and circular capture into a host-accessible spy memory
`timescale 1ns/1ps

module spy_channel (
	input  logic                  spy_clock,        // single clock for stream and spy port
	input  logic                  axi_reset_n,      // sync reset, active low
	input  logic                  sb_reset_i,       // soft reset of this channel only
	input  logic                  freeze_i,         // level, stops capture and holds pointer
	input  fm_spy_pkg::mon_word_t mon_data_i,       // monitored word
	input  logic                  mon_vld_i,        // strobe qualifying mon_data_i
	input  logic                  mem_en_i,         // spy port enable, read or write
	input  logic                  mem_wr_en_i,      // spy port write strobe
	input  fm_spy_pkg::spy_addr_t mem_addr_i,       // spy port address
	input  fm_spy_pkg::mon_word_t mem_wr_data_i,    // spy port write word
	output fm_spy_pkg::mon_word_t mem_rd_data_o,    // registered spy read word
	output fm_spy_pkg::mon_word_t playback_data_o,  // delayed copy of the stream
	output logic                  playback_vld_o    // valid of the delayed copy
);
	import fm_spy_pkg::*;

	logic      chan_rst;                 // global or soft reset
	logic      capture_en;               // record this word
	logic      spy_wr;                   // spy port write this cycle
	spy_addr_t capture_ptr;              // next capture location
	mon_word_t pass_data_q;              // passthrough word
	logic      pass_vld_q;               // passthrough valid
	mon_word_t rd_data_q;                // spy read register
	mon_word_t spy_mem [spy_depth];      // circular spy memory

	assign chan_rst = ~axi_reset_n | sb_reset_i;

	// capture only live words, never while frozen or held in reset
	assign capture_en = mon_vld_i & ~freeze_i & ~chan_rst;

	assign spy_wr = mem_en_i & mem_wr_en_i;

	// passthrough valid, one cycle behind the input strobe
	always_ff @(posedge spy_clock)
	begin
		if (chan_rst)
		begin
			pass_vld_q <= 1'b0;          // no stale word after reset
		end
		else
		begin
			pass_vld_q <= mon_vld_i;
		end
	end

	// passthrough word, loaded only on a valid strobe
	always_ff @(posedge spy_clock)
	begin
		if (mon_vld_i)
		begin
			pass_data_q <= mon_data_i;
		end
	end

	// idle cycles show zero on the playback bus
	assign playback_data_o = pass_vld_q ? pass_data_q : '0;
	assign playback_vld_o  = pass_vld_q;

	// capture pointer, increments per recorded word
	always_ff @(posedge spy_clock)
	begin
		if (chan_rst)
		begin
			capture_ptr <= '0;           // restart capture at address 0
		end
		else if (capture_en)
		begin
			capture_ptr <= capture_ptr + 1'b1;   // wraps at spy_depth by width
		end
	end

	// spy memory, capture write port plus the spy read/write port
	always_ff @(posedge spy_clock)
	begin
		if (capture_en)
		begin
			spy_mem[capture_ptr] <= mon_data_i;
		end
		if (spy_wr)
		begin
			spy_mem[mem_addr_i] <= mem_wr_data_i;   // last assignment, spy write wins a clash
		end
		if (mem_en_i)
		begin
			rd_data_q <= spy_mem[mem_addr_i];       // old word on read during write
		end
	end

	assign mem_rd_data_o = rd_data_q;

endmodule

// File: hdl/spy_access_ctrl.sv
// spy access controller with the init sweep, host/sweep port muxing and registered read valids
`timescale 1ns/1ps

module spy_access_ctrl #(
	parameter int n_channels = fm_spy_pkg::n_channels_default   // number of spy channels
) (
	input  logic                  spy_clock,                    // spy clock
	input  logic                  axi_reset_n,                  // sync reset, active low
	input  logic                  init_spy_mem_i,               // level, keeps the sweep running
	input  logic [n_channels-1:0] spy_en_i,                     // host read enables
	input  logic [n_channels-1:0] spy_wr_en_i,                  // host write enables
	input  fm_spy_pkg::spy_addr_t spy_addr_i    [n_channels],   // host addresses
	input  fm_spy_pkg::mon_word_t spy_wr_data_i [n_channels],   // host write words
	input  fm_spy_pkg::mon_word_t mem_rd_data_i [n_channels],   // read words from channels
	output logic [n_channels-1:0] mem_en_o,                     // per-channel port enable
	output logic [n_channels-1:0] mem_wr_en_o,                  // per-channel write strobe
	output fm_spy_pkg::spy_addr_t mem_addr_o    [n_channels],   // per-channel address
	output fm_spy_pkg::mon_word_t mem_wr_data_o [n_channels],   // per-channel write word
	output fm_spy_pkg::mon_word_t spy_rd_data_o [n_channels],   // host read words
	output logic [n_channels-1:0] spy_rd_valid_o                // host read valids
);
	import fm_spy_pkg::*;

	logic                  init_active;   // sweep running
	spy_addr_t             sweep_addr;    // sweep location, shared by all channels
	logic [n_channels-1:0] rd_vld_q;      // registered read valids

	// init flag, set by reset then follows the request one cycle late
	always_ff @(posedge spy_clock)
	begin
		if (!axi_reset_n)
		begin
			init_active <= 1'b1;          // memories get filled out of reset
		end
		else
		begin
			init_active <= init_spy_mem_i;
		end
	end

	// sweep address counter
	always_ff @(posedge spy_clock)
	begin
		if (!axi_reset_n)
		begin
			sweep_addr <= '0;
		end
		else if (init_active)
		begin
			sweep_addr <= sweep_addr + 1'b1;   // wraps at spy_depth by width
		end
		else
		begin
			sweep_addr <= '0;             // parked at 0 between sweeps
		end
	end

	// port select, the sweep owns every channel while active
	always_comb
	begin
		for (int i = 0; i < n_channels; i++)
		begin
			if (init_active)
			begin
				mem_en_o[i]      = 1'b1;
				mem_wr_en_o[i]   = 1'b1;              // host writes dropped here
				mem_addr_o[i]    = sweep_addr;
				mem_wr_data_o[i] = init_pattern;
			end
			else
			begin
				mem_en_o[i]      = spy_en_i[i] | spy_wr_en_i[i];
				mem_wr_en_o[i]   = spy_wr_en_i[i];
				mem_addr_o[i]    = spy_addr_i[i];
				mem_wr_data_o[i] = spy_wr_data_i[i];
			end
		end
	end

	// read valid, one cycle after the host enable
	always_ff @(posedge spy_clock)
	begin
		if (!axi_reset_n)
		begin
			rd_vld_q <= '0;
		end
		else
		begin
			rd_vld_q <= spy_en_i;
		end
	end

	// zero data outside a valid cycle
	always_comb
	begin
		for (int i = 0; i < n_channels; i++)
		begin
			spy_rd_data_o[i] = rd_vld_q[i] ? mem_rd_data_i[i] : '0;
		end
	end

	assign spy_rd_valid_o = rd_vld_q;

endmodule

// File: hdl/fm_spy_top.sv
// front-end monitor spy bank top level, one access controller and n_channels spy channels
`timescale 1ns/1ps

module fm_spy_top #(
	parameter int n_channels = fm_spy_pkg::n_channels_default     // channels in the bank
) (
	input  logic                  spy_clock,                      // single clock
	input  logic                  axi_reset_n,                    // sync reset, active low
	input  logic                  init_spy_mem_i,                 // init sweep request, all channels
	input  fm_spy_pkg::mon_word_t mon_data_i      [n_channels],   // monitored words
	input  logic [n_channels-1:0] mon_vld_i,                      // monitored strobes
	input  logic [n_channels-1:0] freeze_i,                       // capture freeze levels
	input  logic [n_channels-1:0] sb_reset_i,                     // soft resets
	input  logic [n_channels-1:0] spy_en_i,                       // host read enables
	input  logic [n_channels-1:0] spy_wr_en_i,                    // host write enables
	input  fm_spy_pkg::spy_addr_t spy_addr_i      [n_channels],   // host addresses
	input  fm_spy_pkg::mon_word_t spy_wr_data_i   [n_channels],   // host write words
	output fm_spy_pkg::mon_word_t spy_rd_data_o   [n_channels],   // host read words
	output logic [n_channels-1:0] spy_rd_valid_o,                 // host read valids
	output fm_spy_pkg::mon_word_t playback_data_o [n_channels],   // delayed stream
	output logic [n_channels-1:0] playback_vld_o                  // delayed strobes
);
	import fm_spy_pkg::*;

	logic [n_channels-1:0] mem_en;                   // muxed port enables
	logic [n_channels-1:0] mem_wr_en;                // muxed write strobes
	spy_addr_t             mem_addr    [n_channels]; // muxed addresses
	mon_word_t             mem_wr_data [n_channels]; // muxed write words
	mon_word_t             mem_rd_data [n_channels]; // raw read words

	// host/sweep arbitration and read valids
	spy_access_ctrl #(
		.n_channels (n_channels)
	) u_access_ctrl (
		.spy_clock      (spy_clock),
		.axi_reset_n    (axi_reset_n),
		.init_spy_mem_i (init_spy_mem_i),
		.spy_en_i       (spy_en_i),
		.spy_wr_en_i    (spy_wr_en_i),
		.spy_addr_i     (spy_addr_i),
		.spy_wr_data_i  (spy_wr_data_i),
		.mem_rd_data_i  (mem_rd_data),
		.mem_en_o       (mem_en),
		.mem_wr_en_o    (mem_wr_en),
		.mem_addr_o     (mem_addr),
		.mem_wr_data_o  (mem_wr_data),
		.spy_rd_data_o  (spy_rd_data_o),
		.spy_rd_valid_o (spy_rd_valid_o)
	);

	// one spy channel per monitored stream
	genvar ch;
	generate
		for (ch = 0; ch < n_channels; ch++)
		begin : g_channel
			spy_channel u_spy_channel (
				.spy_clock       (spy_clock),
				.axi_reset_n     (axi_reset_n),
				.sb_reset_i      (sb_reset_i[ch]),
				.freeze_i        (freeze_i[ch]),
				.mon_data_i      (mon_data_i[ch]),
				.mon_vld_i       (mon_vld_i[ch]),
				.mem_en_i        (mem_en[ch]),
				.mem_wr_en_i     (mem_wr_en[ch]),
				.mem_addr_i      (mem_addr[ch]),
				.mem_wr_data_i   (mem_wr_data[ch]),
				.mem_rd_data_o   (mem_rd_data[ch]),
				.playback_data_o (playback_data_o[ch]),
				.playback_vld_o  (playback_vld_o[ch])
			);
		end
	endgenerate

endmodule

// File: verification/tb_clock_gen.sv
// testbench clock and reset source driving the spy bank
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int period_ns    = 8,    // spy clock period
	parameter int reset_cycles = 8     // clocks with reset held low
) (
	output logic spy_clock,
	output logic axi_reset_n
);

	initial
	begin
		spy_clock = 1'b0;
		forever #(period_ns / 2) spy_clock = ~spy_clock;
	end

	// reset low for reset_cycles rising edges then released on an edge
	initial
	begin
		axi_reset_n <= 1'b0;
		repeat (reset_cycles) @(posedge spy_clock);
		axi_reset_n <= 1'b1;
	end

endmodule

// File: verification/fm_spy_assertions.sv
// protocol checks on the spy access controller, read valid timing, idle data and sweep ownership
`timescale 1ns/1ps

module fm_spy_assertions #(
	parameter int n_channels = fm_spy_pkg::n_channels_default   // channels in the bank
) (
	input logic                  spy_clock,
	input logic                  axi_reset_n,
	input logic                  init_active_i,                  // sweep flag of the controller
	input fm_spy_pkg::spy_addr_t sweep_addr_i,                   // sweep location
	input logic [n_channels-1:0] spy_en_i,                       // host read enables
	input logic [n_channels-1:0] mem_wr_en_o,                    // muxed write strobes
	input fm_spy_pkg::spy_addr_t mem_addr_o    [n_channels],     // muxed addresses
	input fm_spy_pkg::mon_word_t mem_wr_data_o [n_channels],     // muxed write words
	input fm_spy_pkg::mon_word_t spy_rd_data_o [n_channels],     // host read words
	input logic [n_channels-1:0] spy_rd_valid_o                  // host read valids
);
	import fm_spy_pkg::*;

	genvar i;
	generate
		for (i = 0; i < n_channels; i++)
		begin : g_lane
			// enable gives a valid on the next edge
			a_valid_after_en: assert property (@(posedge spy_clock) disable iff (!axi_reset_n)
				spy_en_i[i] |=> spy_rd_valid_o[i])
			else $error("read valid missing after enable on channel %0d", i);

			// and only then, so the valid lasts one cycle
			a_valid_single: assert property (@(posedge spy_clock) disable iff (!axi_reset_n)
				!spy_en_i[i] |=> !spy_rd_valid_o[i])
			else $error("read valid without a preceding enable on channel %0d", i);

			a_idle_data_zero: assert property (@(posedge spy_clock)
				!spy_rd_valid_o[i] |-> (spy_rd_data_o[i] == '0))
			else $error("read data not zero while valid is low on channel %0d", i);

			// host write must not reach the memory port during the sweep
			a_sweep_owns_port: assert property (@(posedge spy_clock)
				init_active_i |-> (mem_wr_en_o[i] && (mem_addr_o[i] == sweep_addr_i)
					&& (mem_wr_data_o[i] == init_pattern)))
			else $error("host access reached the spy memory during init on channel %0d", i);
		end
	endgenerate

endmodule

// File: verification/fm_spy_tb.sv
// testbench for the spy bank, random stream and host traffic checked against a reference model
`timescale 1ns/1ps

module fm_spy_tb;
	import fm_spy_pkg::*;

	localparam int n_ch       = n_channels_default;          // channels under test
	localparam int drain_len  = 3;                           // idle cycles closing each test
	localparam int pass_len   = 100;
	localparam int stream_len = spy_depth + spy_depth / 2 + 16;   // enough words to wrap
	localparam int frozen_len = 40;
	localparam int access_len = 80;
	localparam int test_cycles = 10
		+ (2 * spy_depth + 8)                      // init sweep and readback
		+ (pass_len + 4)                           // passthrough
		+ (stream_len + spy_depth + 6)             // capture and wrap
		+ (frozen_len + spy_depth + 12)            // freeze
		+ (access_len + spy_depth + 10)            // host access
		+ (spy_depth + 30);                        // soft reset
	localparam int cycle_limit = test_cycles + 200;

	logic            spy_clock;
	logic            axi_reset_n;
	logic            init_spy_mem;
	mon_word_t       mon_data      [n_ch];
	logic [n_ch-1:0] mon_vld;
	logic [n_ch-1:0] freeze;
	logic [n_ch-1:0] sb_reset;
	logic [n_ch-1:0] spy_en;
	logic [n_ch-1:0] spy_wr_en;
	spy_addr_t       spy_addr      [n_ch];
	mon_word_t       spy_wr_data   [n_ch];
	mon_word_t       spy_rd_data   [n_ch];
	logic [n_ch-1:0] spy_rd_valid;
	mon_word_t       playback_data [n_ch];
	logic [n_ch-1:0] playback_vld;

	// reference model state
	mon_word_t       m_mem [n_ch][spy_depth];   // expected memory contents
	spy_addr_t       m_ptr [n_ch];              // expected capture pointers
	logic            m_init  = 1'b1;            // init flag, set out of reset
	spy_addr_t       m_sweep = '0;
	logic [n_ch-1:0] exp_pb_vld;
	logic [n_ch-1:0] exp_rd_vld;
	mon_word_t       exp_pb_data [n_ch];
	mon_word_t       exp_rd_data [n_ch];
	logic            model_ready    = 1'b0;
	logic            expect_pattern = 1'b0;     // readback must show the fill word

	int seed         = 96;
	int error_count  = 0;
	int check_count  = 0;
	int test_count   = 0;
	int failed_tests = 0;
	int cycle_count  = 0;

	tb_clock_gen #(
		.period_ns    (8),
		.reset_cycles (8)
	) u_clock_gen (
		.spy_clock   (spy_clock),
		.axi_reset_n (axi_reset_n)
	);

	fm_spy_top #(
		.n_channels (n_ch)
	) UUT (
		.spy_clock       (spy_clock),
		.axi_reset_n     (axi_reset_n),
		.init_spy_mem_i  (init_spy_mem),
		.mon_data_i      (mon_data),
		.mon_vld_i       (mon_vld),
		.freeze_i        (freeze),
		.sb_reset_i      (sb_reset),
		.spy_en_i        (spy_en),
		.spy_wr_en_i     (spy_wr_en),
		.spy_addr_i      (spy_addr),
		.spy_wr_data_i   (spy_wr_data),
		.spy_rd_data_o   (spy_rd_data),
		.spy_rd_valid_o  (spy_rd_valid),
		.playback_data_o (playback_data),
		.playback_vld_o  (playback_vld)
	);

	bind spy_access_ctrl fm_spy_assertions #(
		.n_channels (n_channels)
	) u_spy_assertions (
		.spy_clock      (spy_clock),
		.axi_reset_n    (axi_reset_n),
		.init_active_i  (init_active),
		.sweep_addr_i   (sweep_addr),
		.spy_en_i       (spy_en_i),
		.mem_wr_en_o    (mem_wr_en_o),
		.mem_addr_o     (mem_addr_o),
		.mem_wr_data_o  (mem_wr_data_o),
		.spy_rd_data_o  (spy_rd_data_o),
		.spy_rd_valid_o (spy_rd_valid_o)
	);

	function automatic logic [31:0] rand_bits();
		return $random(seed);
	endfunction

	// outputs after the last edge against what the model predicted for it
	task automatic compare_outputs();
		for (int ch = 0; ch < n_ch; ch++)
		begin
			check_count += 4;
			assert (playback_vld[ch] == exp_pb_vld[ch])
			else
			begin
				$display("Error: playback_vld_o[%0d] = %h, expected %h",
					ch, playback_vld[ch], exp_pb_vld[ch]);
				error_count++;
			end
			assert (playback_data[ch] == exp_pb_data[ch])
			else
			begin
				$display("Error: playback_data_o[%0d] = %h, expected %h",
					ch, playback_data[ch], exp_pb_data[ch]);
				error_count++;
			end
			assert (spy_rd_valid[ch] == exp_rd_vld[ch])
			else
			begin
				$display("Error: spy_rd_valid_o[%0d] = %h, expected %h",
					ch, spy_rd_valid[ch], exp_rd_vld[ch]);
				error_count++;
			end
			assert (spy_rd_data[ch] == exp_rd_data[ch])
			else
			begin
				$display("Error: spy_rd_data_o[%0d] = %h, expected %h",
					ch, spy_rd_data[ch], exp_rd_data[ch]);
				error_count++;
			end
			if (expect_pattern && exp_rd_vld[ch])
			begin
				assert (spy_rd_data[ch] == init_pattern)
				else
				begin
					$display("Error: spy_rd_data_o[%0d] = %h, expected %h",
						ch, spy_rd_data[ch], init_pattern);
					error_count++;
				end
			end
		end
	endtask

	// inputs are stable at the falling edge, predict the next rising edge
	always @(negedge spy_clock)
	begin : model_step
		logic chan_rst;
		logic capture;
		if (model_ready)
		begin
			compare_outputs();
		end
		for (int ch = 0; ch < n_ch; ch++)
		begin
			exp_rd_vld[ch]  = axi_reset_n & spy_en[ch];
			exp_rd_data[ch] = exp_rd_vld[ch] ? m_mem[ch][spy_addr[ch]] : '0;   // word before writes
			chan_rst = ~axi_reset_n | sb_reset[ch];
			capture  = mon_vld[ch] & ~freeze[ch] & ~chan_rst;
			if (capture)
			begin
				m_mem[ch][m_ptr[ch]] = mon_data[ch];
			end
			if (m_init)
			begin
				m_mem[ch][m_sweep] = init_pattern;          // host writes dropped
			end
			else if (spy_wr_en[ch])
			begin
				m_mem[ch][spy_addr[ch]] = spy_wr_data[ch];  // beats a capture to the same word
			end
			if (chan_rst)
			begin
				m_ptr[ch] = '0;
			end
			else if (capture)
			begin
				m_ptr[ch] = m_ptr[ch] + spy_addr_t'(1);     // wraps at spy_depth
			end
			exp_pb_vld[ch]  = ~chan_rst & mon_vld[ch];
			exp_pb_data[ch] = exp_pb_vld[ch] ? mon_data[ch] : '0;
		end
		if (!axi_reset_n)
		begin
			m_sweep = '0;
			m_init  = 1'b1;
		end
		else
		begin
			m_sweep = m_init ? m_sweep + spy_addr_t'(1) : '0;
			m_init  = init_spy_mem;                         // follows the request one cycle late
		end
		model_ready = 1'b1;
	end

	always @(posedge spy_clock)
	begin
		cycle_count++;
		if (cycle_count >= cycle_limit)
		begin
			$display("timeout, tests still running after %0d cycles", cycle_count);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic clear_strobes();
		mon_vld   <= '0;
		sb_reset  <= '0;
		spy_en    <= '0;
		spy_wr_en <= '0;
	endtask

	task automatic stream_words(input int n_cycles);
		logic [31:0] r;
		repeat (n_cycles)
		begin
			@(posedge spy_clock);
			for (int ch = 0; ch < n_ch; ch++)
			begin
				r = rand_bits();
				mon_vld[ch]  <= (r[1:0] != 2'b00);   // about three words in four cycles
				mon_data[ch] <= rand_bits();
			end
		end
		@(posedge spy_clock);
		mon_vld <= '0;
	endtask

	// same address on every channel, one per cycle
	task automatic read_all();
		for (int a = 0; a < spy_depth; a++)
		begin
			@(posedge spy_clock);
			spy_en <= '1;
			for (int ch = 0; ch < n_ch; ch++)
			begin
				spy_addr[ch] <= spy_addr_t'(a);
			end
		end
		@(posedge spy_clock);
		spy_en <= '0;
	endtask

	task automatic random_access(input int n_cycles);
		logic [31:0] r;
		repeat (n_cycles)
		begin
			@(posedge spy_clock);
			for (int ch = 0; ch < n_ch; ch++)
			begin
				r = rand_bits();
				spy_en[ch]      <= r[0];
				spy_wr_en[ch]   <= r[1];
				mon_vld[ch]     <= r[2];
				freeze[ch]      <= r[3] & r[4];   // mostly capturing
				spy_addr[ch]    <= r[8 +: spy_aw];
				spy_wr_data[ch] <= rand_bits();
				mon_data[ch]    <= rand_bits();
			end
		end
	endtask

	// host write aimed at the capture pointer in the cycle a word is captured
	task automatic write_over_capture();
		@(posedge spy_clock);
		freeze    <= '0;
		mon_vld   <= '1;
		spy_wr_en <= '1;
		spy_en    <= '0;
		for (int ch = 0; ch < n_ch; ch++)
		begin
			spy_addr[ch]    <= m_ptr[ch];
			spy_wr_data[ch] <= rand_bits();
			mon_data[ch]    <= rand_bits();
		end
		@(posedge spy_clock);
		mon_vld   <= '0;
		spy_wr_en <= '0;
		spy_en    <= '1;                      // read back the clashed words
		@(posedge spy_clock);
		spy_en <= '0;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		clear_strobes();
		repeat (drain_len) @(posedge spy_clock);
		test_count++;
		if (error_count == errors_before)
		begin
			$display("test %-16s ok", name);
		end
		else
		begin
			failed_tests++;
			$display("test %-16s %0d errors", name, error_count - errors_before);
		end
	endtask

	task automatic test_init_sweep();
		int          err_start;
		logic [31:0] r;
		err_start = error_count;
		repeat (spy_depth + 2)
		begin
			@(posedge spy_clock);
			for (int ch = 0; ch < n_ch; ch++)
			begin
				r = rand_bits();
				spy_wr_en[ch]   <= r[31];          // must be ignored by the sweep
				spy_addr[ch]    <= r[spy_aw-1:0];
				spy_wr_data[ch] <= rand_bits();
			end
		end
		@(posedge spy_clock);
		init_spy_mem <= 1'b0;
		spy_wr_en    <= '0;
		repeat (2) @(posedge spy_clock);
		expect_pattern = 1'b1;
		read_all();
		finish_test("init_sweep", err_start);
		expect_pattern = 1'b0;
	endtask

	task automatic test_passthrough();
		int          err_start;
		logic [31:0] r;
		err_start = error_count;
		@(posedge spy_clock);
		r = rand_bits();
		freeze <= r[n_ch-1:0];
		stream_words(pass_len);
		finish_test("passthrough", err_start);
	endtask

	task automatic test_capture_wrap();
		int err_start;
		err_start = error_count;
		@(posedge spy_clock);
		freeze <= '0;
		stream_words(stream_len);
		@(posedge spy_clock);
		freeze <= '1;
		read_all();
		finish_test("capture_wrap", err_start);
	endtask

	task automatic test_freeze();
		int err_start;
		err_start = error_count;
		stream_words(frozen_len);             // still frozen from the previous test
		@(posedge spy_clock);
		freeze <= '0;
		stream_words(4);
		@(posedge spy_clock);
		freeze <= '1;
		read_all();
		finish_test("freeze", err_start);
	endtask

	task automatic test_host_access();
		int err_start;
		err_start = error_count;
		random_access(access_len);
		write_over_capture();
		@(posedge spy_clock);
		clear_strobes();
		freeze <= '1;
		read_all();
		finish_test("host_access", err_start);
	endtask

	task automatic test_soft_reset();
		int          err_start;
		int          victim;
		logic [31:0] r;
		err_start = error_count;
		@(posedge spy_clock);
		freeze <= '0;
		stream_words(5);
		r = rand_bits();
		victim = int'(r % n_ch);
		repeat (2)
		begin
			@(posedge spy_clock);
			sb_reset[victim] <= 1'b1;
			mon_vld          <= '1;            // no capture on the victim
			for (int ch = 0; ch < n_ch; ch++)
			begin
				mon_data[ch] <= rand_bits();
			end
		end
		@(posedge spy_clock);
		sb_reset <= '0;
		mon_vld  <= '0;
		stream_words(10);
		@(posedge spy_clock);
		freeze <= '1;
		read_all();
		finish_test("soft_reset", err_start);
	endtask

	initial
	begin
		init_spy_mem <= 1'b1;                 // sweep held on through reset
		mon_vld      <= '0;
		freeze       <= '0;
		sb_reset     <= '0;
		spy_en       <= '0;
		spy_wr_en    <= '0;
		for (int ch = 0; ch < n_ch; ch++)
		begin
			mon_data[ch]    <= '0;
			spy_addr[ch]    <= '0;
			spy_wr_data[ch] <= '0;
		end
		wait (axi_reset_n === 1'b1);
		test_init_sweep();
		test_passthrough();
		test_capture_wrap();
		test_freeze();
		test_host_access();
		test_soft_reset();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			test_count, failed_tests, check_count, error_count);
		if (error_count == 0 && failed_tests == 0)
		begin
			$display("*** PASSED ***");
		end
		else
		begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: fm_spy.f
hdl/fm_spy_pkg.sv
hdl/spy_channel.sv
hdl/spy_access_ctrl.sv
hdl/fm_spy_top.sv
verification/tb_clock_gen.sv
verification/fm_spy_assertions.sv
verification/fm_spy_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the spy bank testbench with Verilator, run it and search the log for the pass message
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f fm_spy.f --top-module fm_spy_tb -o fm_spy_sim \
	&& ./obj_dir/fm_spy_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "simulation build or run failed"; exit 1; }

cat sim.log
grep -qF "*** PASSED ***" sim.log && exit 0 || exit 1
